/* rf_mmio.f */
design/rf_pkg.sv
design/bram_if.sv
design/rmio_if.sv
design/rf_sram.sv
design/rf_ram.sv
design/eu_relu.sv
design/eu_lane_sum.sv
design/rf_top.sv
bench/rf_asserts.sv
bench/rf_tb.sv

/* Makefile */
# Verilator flow for rf_mmio
VERILATOR ?= verilator
TOP       ?= rf_tb
FILELIST  ?= rf_mmio.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Verdict comes from the log
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/rf_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module rf_tb;
    import rf_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int MARGIN_CYCLES = 50;
    localparam int N_RAND_OPS    = 40;

    // One bus cycle of stimulus plus its expected read data
    typedef struct {
        logic  is_write;
        addr_t addr;
        word_t wdata;
        word_t exp;
        logic  chk;
    } entry_t;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    word_t wdata;
    logic  we;
    logic  re;
    word_t rdata;

    entry_t tbl [$];
    // Reference model state
    word_t  sram_shadow [addr_t];
    word_t  relu_shadow [N_RELU];
    word_t  sum_shadow;
    int     error_count;
    int     check_count;
    logic   table_ready;

    rf_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .wdata (wdata),
        .we    (we),
        .re    (re),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////
    // Negative lanes clamp to zero
    function automatic word_t relu_ref(word_t w);
        word_t r;
        r = w;
        for (int k = 0; k < LANES; k++) begin
            if (w[LANE_W*k + LANE_W-1]) r[LANE_W*k +: LANE_W] = '0;
        end
        return r;
    endfunction

    // Sum of four sign-extended lanes, 32-bit wrap
    function automatic word_t lane_sum_ref(word_t w);
        word_t total;
        total = '0;
        for (int k = 0; k < LANES; k++) begin
            total = total + {{(RF_DATA_W-LANE_W){w[LANE_W*k + LANE_W-1]}}, w[LANE_W*k +: LANE_W]};
        end
        return total;
    endfunction

    task automatic add_write(addr_t a, word_t d);
        tbl.push_back('{is_write: 1'b1, addr: a, wdata: d, exp: '0, chk: 1'b0});
    endtask

    task automatic add_read(addr_t a);
        tbl.push_back('{is_write: 1'b0, addr: a, wdata: '0, exp: '0, chk: 1'b0});
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR: t=%0t %s expected %08h got %08h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    task automatic build_table();
        addr_t       a;
        int unsigned kind;
        // Y reads straight out of reset
        add_read(ADDR_RELU_0_Y);
        add_read(ADDR_RELU_1_Y);
        add_read(ADDR_SUM_0_Y);
        // ReLU units, second read holds, other unit untouched
        add_write(ADDR_RELU_0_X, 32'h807F_FF01);
        add_read(ADDR_RELU_0_Y);
        add_read(ADDR_RELU_0_Y);
        add_read(ADDR_RELU_1_Y);
        add_write(ADDR_RELU_1_X, 32'h10F0_20C0);
        add_read(ADDR_RELU_1_Y);
        add_read(ADDR_RELU_0_Y);
        // Lane sum over one batch, then drained
        add_write(ADDR_SUM_0_X, 32'h0102_0304);
        add_write(ADDR_SUM_0_X, 32'hFFFF_FFFF);
        add_write(ADDR_SUM_0_X, 32'h7F7F_8080);
        add_read(ADDR_SUM_0_Y);
        add_read(ADDR_SUM_0_Y);
        // SRAM words at addresses that MMIO X writes alias
        add_write(8'h00, 32'h1234_5678);
        add_write(8'h01, 32'h9ABC_DEF0);
        add_write(8'h10, 32'h0F0F_1111);
        add_write(ADDR_RELU_0_X, 32'hFFFF_FFFF);
        add_write(ADDR_RELU_1_X, 32'h0000_0000);
        add_write(ADDR_SUM_0_X, 32'h0505_0505);
        add_read(8'h00);
        add_read(8'h01);
        add_read(8'h10);
        // Random mix
        for (int n = 0; n < N_RAND_OPS; n++) begin
            kind = $urandom_range(3, 0);
            case (kind)
                0: begin
                    a = addr_t'($urandom_range(127, 0));
                    add_write(a, $urandom());
                    add_read(a);
                end
                1: add_read(addr_t'($urandom_range(127, 0)));
                2: begin
                    a = ($urandom_range(1, 0) != 0) ? ADDR_RELU_1_X : ADDR_RELU_0_X;
                    add_write(a, $urandom());
                    // Y sits 8 above X
                    add_read(a | 8'h08);
                end
                default: begin
                    repeat ($urandom_range(3, 1)) add_write(ADDR_SUM_0_X, $urandom());
                    add_read(ADDR_SUM_0_Y);
                end
            endcase
        end
    endtask

    // Walk the table through the model
    task automatic fill_expected();
        entry_t e;
        sum_shadow = '0;
        foreach (relu_shadow[u]) relu_shadow[u] = '0;
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            if (e.is_write) begin
                case (e.addr)
                    ADDR_RELU_0_X: relu_shadow[0] = relu_ref(e.wdata);
                    ADDR_RELU_1_X: relu_shadow[1] = relu_ref(e.wdata);
                    ADDR_SUM_0_X:  sum_shadow = sum_shadow + lane_sum_ref(e.wdata);
                    // Unmapped MMIO writes are lost
                    default:       if (e.addr < 8'h80) sram_shadow[e.addr] = e.wdata;
                endcase
            end else begin
                e.chk = 1'b1;
                case (e.addr)
                    ADDR_RELU_0_Y: e.exp = relu_shadow[0];
                    ADDR_RELU_1_Y: e.exp = relu_shadow[1];
                    ADDR_SUM_0_Y: begin
                        e.exp      = sum_shadow;
                        sum_shadow = '0;
                    end
                    default: begin
                        // Never-written words are skipped
                        e.chk = (sram_shadow.exists(e.addr) != 0);
                        if (e.chk) e.exp = sram_shadow[e.addr];
                    end
                endcase
            end
            tbl[i] = e;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        entry_t prev;
        logic   prev_chk;
        void'($urandom(32'h381));
        rst_n       = 1'b0;
        addr        = '0;
        wdata       = '0;
        we          = 1'b0;
        re          = 1'b0;
        error_count = 0;
        check_count = 0;
        prev_chk    = 1'b0;
        table_ready = 1'b0;
        build_table();
        fill_expected();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            #2;
            // Result of the read strobed one cycle earlier
            if (prev_chk) check_value($sformatf("rdata[%02h]", prev.addr), prev.exp, rdata);
            addr     = tbl[i].addr;
            wdata    = tbl[i].wdata;
            we       = tbl[i].is_write;
            re       = !tbl[i].is_write;
            prev     = tbl[i];
            prev_chk = !tbl[i].is_write && tbl[i].chk;
        end
        @(posedge clk);
        #2;
        if (prev_chk) check_value($sformatf("rdata[%02h]", prev.addr), prev.exp, rdata);
        we = 1'b0;
        re = 1'b0;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, sized from the table once it exists
    initial begin
        wait (table_ready === 1'b1);
        #((tbl.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the table did not finish in the expected number of cycles");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rf_asserts.sv */
`default_nettype none
`timescale 1ns/1ps

// Decode checks on the host side of rf_ram
module rf_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           we,
    input logic                           re,
    input rf_pkg::addr_t                  addr,
    // All unit strobes plus both SRAM strobes
    input logic [2*rf_pkg::N_RELU+3:0]    strobes,
    input logic                           sram_strobe
);
    import rf_pkg::*;

    ////////////////////////////////////////
    // Properties
    ////////////////////////////////////////
    a_we_re_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(we && re))
        else $error("we and re both high in one cycle");

    // One target per bus cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) $countones(strobes) <= 1)
        else $error("more than one decode strobe high");

    // Every low-half access reaches the SRAM, the MMIO half never does
    a_sram_low_only: assert property (@(posedge clk) disable iff (!rst_n)
        sram_strobe == ((we || re) && (addr < 2**SRAM_ADDR_W)))
        else $error("SRAM strobe %0b for address %02h", sram_strobe, addr);

endmodule

bind rf_ram rf_asserts u_rf_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .we          (ram.we),
    .re          (ram.re),
    .addr        (ram.addr),
    .strobes     ({relu_we, relu_re, lsum_we, lsum_re, sram_we, sram_re}),
    .sram_strobe (sram_we | sram_re)
);

`default_nettype wire

/* design/rf_top.sv */
`default_nettype none
`timescale 1ns/1ps

module rf_top (
    input  logic          clk,
    input  logic          rst_n,
    input  rf_pkg::addr_t addr,
    input  rf_pkg::word_t wdata,
    input  logic          we,
    input  logic          re,
    output rf_pkg::word_t rdata
);
    import rf_pkg::*;

    ////////////////////////////////////////
    // Buses
    ////////////////////////////////////////
    // Full host address
    bram_if #(.ADDR_W(RF_ADDR_W))   host_bus ();
    // SRAM needs only the low bits
    bram_if #(.ADDR_W(SRAM_ADDR_W)) sram_bus ();
    rmio_if relu_io [N_RELU] ();
    rmio_if lsum_io ();

    // Host pins onto the bus
    assign host_bus.addr = addr;
    assign host_bus.data = wdata;
    assign host_bus.we   = we;
    assign host_bus.re   = re;
    assign rdata         = host_bus.q;

    ////////////////////////////////////////
    // Decoder and storage
    ////////////////////////////////////////
    rf_ram u_rf_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .ram   (host_bus.memory),
        .sram  (sram_bus.host),
        .relu  (relu_io),
        .lsum  (lsum_io.decoder)
    );

    rf_sram u_rf_sram (
        .clk (clk),
        .mem (sram_bus.memory)
    );

    // Execution units
    for (genvar i = 0; i < N_RELU; i++) begin : g_relu
        eu_relu u_eu_relu (
            .clk   (clk),
            .rst_n (rst_n),
            .io    (relu_io[i].unit)
        );
    end

    eu_lane_sum u_eu_lane_sum (
        .clk   (clk),
        .rst_n (rst_n),
        .io    (lsum_io.unit)
    );

endmodule

`default_nettype wire

/* design/eu_lane_sum.sv */
`default_nettype none
`timescale 1ns/1ps

module eu_lane_sum (
    input  logic clk,
    input  logic rst_n,
    rmio_if.unit io
);
    import rf_pkg::*;

    rf_word_u                    x_w;
    logic signed [RF_DATA_W-1:0] lane_total;
    logic signed [RF_DATA_W-1:0] acc_q;
    logic signed [RF_DATA_W-1:0] acc_base;
    rf_word_u                    rd_q;

    assign x_w = io.input_data;

    ////////////////////////////////////////
    // Lane adder
    ////////////////////////////////////////
    always_comb begin
        lane_total = '0;
        for (int k = 0; k < LANES; k++) begin
            // Sign-extend each lane to full width
            lane_total = lane_total + RF_DATA_W'(x_w.lanes[k]);
        end
    end

    // A read starts a new batch from zero
    assign acc_base = io.output_re ? '0 : acc_q;

    ////////////////////////////////////////
    // Accumulator and read register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (io.input_we || io.output_re) begin
            // Wraps on overflow
            acc_q <= acc_base + (io.input_we ? lane_total : '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (io.output_re) begin
            // Total before this cycle's write
            rd_q.scalar <= acc_q;
        end
    end

    assign io.output_data = rd_q.scalar;

endmodule

`default_nettype wire

/* design/eu_relu.sv */
`default_nettype none
`timescale 1ns/1ps

module eu_relu (
    input  logic clk,
    input  logic rst_n,
    rmio_if.unit io
);
    import rf_pkg::*;

    rf_word_u x_w;
    rf_word_u relu_w;
    rf_word_u y_q;

    assign x_w = io.input_data;

    ////////////////////////////////////////
    // Lane-wise clamp
    ////////////////////////////////////////
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            // Sign bit set means negative, clamp to zero
            relu_w.lanes[k] = x_w.lanes[k][LANE_W-1] ? '0 : x_w.lanes[k];
        end
    end

    // Result register, reads leave it untouched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_q <= '0;
        end else if (io.input_we) begin
            y_q <= relu_w;
        end
    end

    // output_re has no effect here
    assign io.output_data = y_q;

endmodule

`default_nettype wire

/* design/rf_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module rf_ram (
    input  logic   clk,
    input  logic   rst_n,
    // Host side
    bram_if.memory ram,
    // SRAM side
    bram_if.host   sram,
    // Execution units
    rmio_if.decoder relu [rf_pkg::N_RELU],
    rmio_if.decoder lsum
);
    import rf_pkg::*;

    logic              is_sram_addr;
    addr_t             addr_ff;
    logic [N_RELU-1:0] relu_we;
    logic [N_RELU-1:0] relu_re;
    logic              lsum_we;
    logic              lsum_re;
    logic              sram_we;
    logic              sram_re;
    word_t             relu_q [N_RELU];

    ////////////////////////////////////////
    // Data and address fan-out
    ////////////////////////////////////////
    // Write data goes everywhere, strobes pick the target
    assign sram.data = ram.data;
    assign sram.addr = ram.addr[SRAM_ADDR_W-1:0];
    assign sram.we   = sram_we;
    assign sram.re   = sram_re;

    assign lsum.input_data = ram.data;
    assign lsum.input_we   = lsum_we;
    assign lsum.output_re  = lsum_re;

    for (genvar i = 0; i < N_RELU; i++) begin : g_relu_link
        assign relu[i].input_data = ram.data;
        assign relu[i].input_we   = relu_we[i];
        assign relu[i].output_re  = relu_re[i];
        // Collected so the read mux can index by constant
        assign relu_q[i]          = relu[i].output_data;
    end

    // Low half of the map
    assign is_sram_addr = ram.addr < (2 ** SRAM_ADDR_W);

    ////////////////////////////////////////
    // Write strobes
    ////////////////////////////////////////
    always_comb begin
        relu_we = '0;
        lsum_we = 1'b0;
        sram_we = 1'b0;
        if (ram.we) begin
            case (ram.addr)
                ADDR_RELU_0_X: relu_we[0] = 1'b1;
                ADDR_RELU_1_X: relu_we[1] = 1'b1;
                ADDR_SUM_0_X:  lsum_we    = 1'b1;
                // Unmapped MMIO writes fall through and are dropped
                default:       sram_we    = is_sram_addr;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read strobes
    ////////////////////////////////////////
    always_comb begin
        relu_re = '0;
        lsum_re = 1'b0;
        sram_re = 1'b0;
        if (ram.re) begin
            case (ram.addr)
                ADDR_RELU_0_Y: relu_re[0] = 1'b1;
                ADDR_RELU_1_Y: relu_re[1] = 1'b1;
                // Drains the accumulator
                ADDR_SUM_0_Y:  lsum_re    = 1'b1;
                default:       sram_re    = is_sram_addr;
            endcase
        end
    end

    ////////////////////////////////////////
    // Address pipeline
    ////////////////////////////////////////
    // Lines up with the one-cycle SRAM and unit read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
        end else begin
            addr_ff <= ram.addr;
        end
    end

    ////////////////////////////////////////
    // Read data steering
    ////////////////////////////////////////
    always_comb begin
        case (addr_ff)
            ADDR_RELU_0_Y: ram.q = relu_q[0];
            ADDR_RELU_1_Y: ram.q = relu_q[1];
            ADDR_SUM_0_Y:  ram.q = lsum.output_data;
            // SRAM, also whatever it holds for unmapped MMIO
            default:       ram.q = sram.q;
        endcase
    end

endmodule

`default_nettype wire

/* design/rf_sram.sv */
`default_nettype none
`timescale 1ns/1ps

module rf_sram (
    input  logic clk,
    bram_if.memory mem
);
    import rf_pkg::*;

    // Storage array, 128 words
    word_t store [2**SRAM_ADDR_W];
    // Registered read port
    word_t q_r;

    always_ff @(posedge clk) begin
        if (mem.we) begin
            store[mem.addr] <= mem.data;
        end
        // Holds last read word until next re
        if (mem.re) begin
            q_r <= store[mem.addr];
        end
    end

    assign mem.q = q_r;

endmodule

`default_nettype wire

/* design/rmio_if.sv */
`default_nettype none
`timescale 1ns/1ps

// Link from the decoder to one execution unit
interface rmio_if;
    import rf_pkg::*;

    // Broadcast write data
    word_t input_data;
    // Write strobe for the X address
    logic  input_we;
    // Read strobe for the Y address
    logic  output_re;
    // Unit result, steered to the host
    word_t output_data;

    modport decoder (output input_data, input_we, output_re, input output_data);
    modport unit    (input input_data, input_we, output_re, output output_data);

endinterface

`default_nettype wire

/* design/bram_if.sv */
`default_nettype none
`timescale 1ns/1ps

// One single-port RAM port, address width set per instance
interface bram_if #(
    parameter int ADDR_W = rf_pkg::RF_ADDR_W
);
    import rf_pkg::*;

    logic [ADDR_W-1:0] addr;
    word_t             data;
    logic              we;
    logic              re;
    // Read data, one cycle behind re
    word_t             q;

    modport host   (output addr, data, we, re, input q);
    modport memory (input addr, data, we, re, output q);

endinterface

`default_nettype wire

/* design/rf_pkg.sv */
`default_nettype none

package rf_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int RF_DATA_W   = 32;
    localparam int RF_ADDR_W   = 8;
    // Anything below 2**SRAM_ADDR_W lands in the SRAM
    localparam int SRAM_ADDR_W = 7;
    localparam int LANES       = 4;
    localparam int LANE_W      = 8;
    // Number of ReLU execution units
    localparam int N_RELU      = 2;

    typedef logic [RF_DATA_W-1:0] word_t;
    typedef logic [RF_ADDR_W-1:0] addr_t;
    typedef logic signed [LANE_W-1:0] lane_t;

    // One bus word, seen as four signed lanes or one signed scalar
    // Lane 0 sits in the low byte
    typedef union packed {
        lane_t [LANES-1:0]            lanes;
        logic signed [RF_DATA_W-1:0]  scalar;
    } rf_word_u;

    ////////////////////////////////////////
    // MMIO map
    ////////////////////////////////////////
    typedef enum addr_t {
        // Unit inputs, write only
        ADDR_RELU_0_X = 8'h80,
        ADDR_RELU_1_X = 8'h81,
        // Unit outputs, read only
        ADDR_RELU_0_Y = 8'h88,
        ADDR_RELU_1_Y = 8'h89,
        // Lane-sum accumulator
        ADDR_SUM_0_X  = 8'h90,
        ADDR_SUM_0_Y  = 8'h98
    } mmio_addr_e;

endpackage

`default_nettype wire
